//--- Bender.yml
package:
  name: ls_cluster

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_if_pkg.sv
      - copy_pkg.sv
      - copy_agu.sv
      - load_store_mixer.sv
      - tcdm_mem.sv
      - ls_cluster_top.sv
      - target: test
        files:
          - tb_ls_cluster.sv

//--- copy_agu.sv
// copy engines, one per channel; source and destination must not overlap
// base and length are sampled at start, later changes do not affect a run
`timescale 1ns/1ps
`include "ls_cluster_macros.svh"

module copy_agu import copy_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                start_i,
  input  addr_t               src_base,
  input  addr_t               dst_base,
  input  addr_t               len,
  output logic  [`LS_NCH-1:0] ld_req,
  output addr_t [`LS_NCH-1:0] ld_addr,
  input  logic  [`LS_NCH-1:0] ld_gnt,
  input  logic  [`LS_NCH-1:0] ld_rvalid,
  input  word_t [`LS_NCH-1:0] ld_rdata,
  output logic  [`LS_NCH-1:0] st_req,
  output addr_t [`LS_NCH-1:0] st_addr,
  output word_t [`LS_NCH-1:0] st_data,
  input  logic  [`LS_NCH-1:0] st_gnt,
  output logic                busy,
  output logic                done
);

  localparam int unsigned DEPTH = `LS_FIFO_DEPTH;
  localparam int unsigned PW    = $clog2(DEPTH);
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic               run_q;   // a run is in flight, or its done is showing
  logic [`LS_NCH-1:0] idle;
  logic               start_ok;

  assign done     = run_q & (&idle);
  assign busy     = run_q & ~(&idle);
  assign start_ok = start_i & ~busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= 1'b0;
    end else if (clear_i) begin
      run_q <= 1'b0;               // abort, no done
    end else if (start_ok) begin
      run_q <= 1'b1;
    end else if (done) begin
      run_q <= 1'b0;
    end
  end

  for (genvar c = 0; c < `LS_NCH; c++) begin : g_ch
    agu_state_e    state_q, state_d;
    addr_t         ld_cnt_q, st_cnt_q;
    addr_t         len_q, src_q, dst_q;
    logic [CW-1:0] out_q;          // loads granted, data not yet back
    logic [CW-1:0] fifo_cnt_q;
    logic [PW-1:0] wr_ptr_q, rd_ptr_q;
    word_t         fifo_q [DEPTH];
    logic          ld_fire, st_fire, room;

    // a word is reserved in the fifo as soon as its load is issued
    assign room    = (CW'(out_q) + CW'(fifo_cnt_q)) < CW'(DEPTH);
    assign ld_req[c]  = (state_q == AGU_RUN) & room & ~clear_i;
    assign ld_addr[c] = src_q + ld_cnt_q;
    assign st_req[c]  = (state_q != AGU_IDLE) & (fifo_cnt_q != '0) & ~clear_i;
    assign st_addr[c] = dst_q + st_cnt_q;
    assign st_data[c] = fifo_q[rd_ptr_q];
    assign ld_fire = ld_req[c] & ld_gnt[c];
    assign st_fire = st_req[c] & st_gnt[c];
    assign idle[c] = (state_q == AGU_IDLE);

    always_comb begin
      state_d = state_q;
      case (state_q)
        AGU_IDLE:  if (start_ok && len != '0) state_d = AGU_RUN;
        AGU_RUN:   if (ld_fire && ld_cnt_q == len_q - 1'b1) state_d = AGU_DRAIN;
        AGU_DRAIN: if (st_fire && st_cnt_q == len_q - 1'b1) state_d = AGU_IDLE;
        default:   state_d = AGU_IDLE;
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q    <= AGU_IDLE;
        ld_cnt_q   <= '0;
        st_cnt_q   <= '0;
        out_q      <= '0;
        fifo_cnt_q <= '0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
      end else if (clear_i) begin
        state_q    <= AGU_IDLE;
        ld_cnt_q   <= '0;
        st_cnt_q   <= '0;
        out_q      <= '0;
        fifo_cnt_q <= '0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
      end else begin
        state_q <= state_d;
        if (state_q == AGU_IDLE) begin
          ld_cnt_q <= '0;
          st_cnt_q <= '0;
        end else begin
          ld_cnt_q <= ld_cnt_q + addr_t'(ld_fire);
          st_cnt_q <= st_cnt_q + addr_t'(st_fire);
        end
        if (ld_fire && !ld_rvalid[c]) out_q <= out_q + 1'b1;
        else if (!ld_fire && ld_rvalid[c]) out_q <= out_q - 1'b1;
        if (ld_rvalid[c] && !st_fire) fifo_cnt_q <= fifo_cnt_q + 1'b1;
        else if (!ld_rvalid[c] && st_fire) fifo_cnt_q <= fifo_cnt_q - 1'b1;
        if (ld_rvalid[c]) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is 2**PW
        if (st_fire) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end

    // channel block c sits at c*len above each base
    always_ff @(posedge clk_i) begin
      if (start_ok && state_q == AGU_IDLE) begin
        len_q <= len;
        src_q <= src_base + addr_t'(c) * len;
        dst_q <= dst_base + addr_t'(c) * len;
      end
      if (ld_rvalid[c]) fifo_q[wr_ptr_q] <= ld_rdata[c];
    end

    // the load credit check must keep a returning word from finding the fifo full
    a_fifo_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ld_rvalid[c] |-> fifo_cnt_q != CW'(DEPTH));

    a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ld_rvalid[c] |-> out_q != '0);
  end

endmodule

//--- copy_pkg.sv
// data types of the copy engines
// widths come from ls_cluster_macros.svh
`include "ls_cluster_macros.svh"

package copy_pkg;

  typedef logic [`LS_DW-1:0] word_t;
  typedef logic [`LS_AW-1:0] addr_t;  // word address, not byte address

  // RUN issues loads and stores, DRAIN only stores what is left
  typedef enum logic [1:0] {
    AGU_IDLE  = 2'd0,
    AGU_RUN   = 2'd1,
    AGU_DRAIN = 2'd2
  } agu_state_e;

endpackage

//--- load_store_mixer.sv
// merges one load port and one store port onto a single memory port
// responses go to the load side only, a store gets nothing back
`timescale 1ns/1ps
`include "ls_cluster_macros.svh"

module load_store_mixer import mem_if_pkg::*; #(
  parameter int unsigned AW = `LS_AW,
  parameter int unsigned DW = `LS_DW
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,

  // load side
  input  logic          ld_req,
  input  logic [AW-1:0] ld_addr,
  output logic          ld_gnt,
  output logic          ld_rvalid,
  output logic [DW-1:0] ld_rdata,

  // store side
  input  logic          st_req,
  input  logic [AW-1:0] st_addr,
  input  logic [DW-1:0] st_data,
  output logic          st_gnt,

  // memory side
  output logic          mem_req,
  output mem_op_e       mem_op,
  output logic [AW-1:0] mem_addr,
  output logic [DW-1:0] mem_wdata,
  input  logic          mem_gnt,
  input  logic          mem_rvalid,
  input  logic [DW-1:0] mem_rdata
);

  logic rr_q;    // 0 favours the load side, 1 the store side
  logic win_st;  // store side owns the memory port this cycle

  // priority only matters when both sides ask at once
  always_comb begin
    if (ld_req && st_req) begin
      win_st = rr_q;
    end else begin
      win_st = st_req;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else if (clear_i) begin
      rr_q <= 1'b0;
    end else if (mem_req && mem_gnt) begin
      rr_q <= ~rr_q;   // move on after every accepted request
    end
  end

  // request path
  assign mem_req   = ld_req | st_req;
  assign mem_op    = win_st ? MEM_STORE : MEM_LOAD;
  assign mem_addr  = win_st ? st_addr : ld_addr;
  assign mem_wdata = st_data;                      // ignored by the memory on loads

  // grant goes back to the winner only
  assign ld_gnt = mem_gnt & ~win_st;
  assign st_gnt = mem_gnt & win_st;

  // only loads are answered, so every valid belongs to the load side
  assign ld_rvalid = mem_rvalid;
  assign ld_rdata  = mem_rdata;

  // the memory grant must never reach a side that did not ask
  a_gnt_to_requester: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ld_gnt |-> ld_req) and (st_gnt |-> st_req));

endmodule

//--- ls_cluster.f
+incdir+.
mem_if_pkg.sv
copy_pkg.sv
copy_agu.sv
load_store_mixer.sv
tcdm_mem.sv
ls_cluster_top.sv
tb_ls_cluster.sv

//--- ls_cluster_macros.svh
// build-wide sizes for the copy cluster
// LS_MEM_WORDS must equal 2**LS_AW, and LS_FIFO_DEPTH must be a power of two
`ifndef LS_CLUSTER_MACROS_SVH
`define LS_CLUSTER_MACROS_SVH

// word and address widths
`define LS_DW 32
`define LS_AW 10

// one engine, one mixer and one memory port per channel
`define LS_NCH 4

`define LS_MEM_WORDS 1024  // full address space, no holes

`define LS_FIFO_DEPTH 4    // per-channel buffer between loads and stores

`endif

//--- ls_cluster_top.sv
// copy cluster: engines, one load/store mixer per channel, shared memory
// start is taken only while busy is low; done pulses once per run
`timescale 1ns/1ps
`include "ls_cluster_macros.svh"

module ls_cluster_top import mem_if_pkg::*, copy_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               start_i,
  input  addr_t              src_base,
  input  addr_t              dst_base,
  input  addr_t              len,
  input  logic [`LS_NCH-1:0] stall,
  output logic               busy,
  output logic               done,
  input  logic               init_we,
  input  addr_t              init_addr,
  input  word_t              init_wdata,
  input  addr_t              dbg_addr,
  output word_t              dbg_rdata
);

  // engine to mixer
  logic    [`LS_NCH-1:0] ld_req, ld_gnt, ld_rvalid;
  addr_t   [`LS_NCH-1:0] ld_addr;
  word_t   [`LS_NCH-1:0] ld_rdata;
  logic    [`LS_NCH-1:0] st_req, st_gnt;
  addr_t   [`LS_NCH-1:0] st_addr;
  word_t   [`LS_NCH-1:0] st_data;

  // mixer to memory
  logic    [`LS_NCH-1:0] mem_req, mem_gnt, mem_rvalid;
  mem_op_e [`LS_NCH-1:0] mem_op;
  addr_t   [`LS_NCH-1:0] mem_addr;
  word_t   [`LS_NCH-1:0] mem_wdata, mem_rdata;

  copy_agu u_copy_agu (
    .clk_i, .rst_ni, .clear_i, .start_i,
    .src_base, .dst_base, .len,
    .ld_req, .ld_addr, .ld_gnt, .ld_rvalid, .ld_rdata,
    .st_req, .st_addr, .st_data, .st_gnt,
    .busy, .done
  );

  for (genvar c = 0; c < `LS_NCH; c++) begin : g_mix
    load_store_mixer #(
      .AW ($bits(addr_t)),
      .DW ($bits(word_t))
    ) u_mixer (
      .clk_i, .rst_ni, .clear_i,
      .ld_req     (ld_req[c]),
      .ld_addr    (ld_addr[c]),
      .ld_gnt     (ld_gnt[c]),
      .ld_rvalid  (ld_rvalid[c]),
      .ld_rdata   (ld_rdata[c]),
      .st_req     (st_req[c]),
      .st_addr    (st_addr[c]),
      .st_data    (st_data[c]),
      .st_gnt     (st_gnt[c]),
      .mem_req    (mem_req[c]),
      .mem_op     (mem_op[c]),
      .mem_addr   (mem_addr[c]),
      .mem_wdata  (mem_wdata[c]),
      .mem_gnt    (mem_gnt[c]),
      .mem_rvalid (mem_rvalid[c]),
      .mem_rdata  (mem_rdata[c])
    );
  end

  tcdm_mem u_tcdm_mem (
    .clk_i, .rst_ni,
    .mem_req, .mem_op, .mem_addr, .mem_wdata, .stall,
    .mem_gnt, .mem_rvalid, .mem_rdata,
    .init_we, .init_addr, .init_wdata, .dbg_addr, .dbg_rdata
  );

endmodule

//--- mem_if_pkg.sv
// kind of a request on a memory port
// a store never produces a response, a load always produces exactly one
package mem_if_pkg;

  // travels with every request in place of a write enable
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

endpackage

//--- tb_ls_cluster.sv
// self-checking testbench for the copy cluster
// all copy regions are disjoint and stay inside the 1024-word space
`timescale 1ns/1ps
`include "ls_cluster_macros.svh"

module tb_ls_cluster import copy_pkg::*; ();

  localparam int unsigned NCH     = `LS_NCH;
  localparam int unsigned WORDS   = `LS_MEM_WORDS;
  localparam int          TIMEOUT = 4000;  // cycles allowed for one run

  logic           clk_i = 1'b0;
  logic           rst_ni;
  logic           clear_i;
  logic           start_i;
  addr_t          src_base;
  addr_t          dst_base;
  addr_t          len;
  logic [NCH-1:0] stall = '0;
  logic           busy;
  logic           done;
  logic           init_we;
  addr_t          init_addr;
  word_t          init_wdata;
  addr_t          dbg_addr;
  word_t          dbg_rdata;

  logic [15:0]    lfsr_q = 16'd72;
  logic           stall_en = 1'b0;
  word_t          image [WORDS];  // memory contents before the current run

  ls_cluster_top u_ls_cluster_top (
    .clk_i, .rst_ni, .clear_i, .start_i,
    .src_base, .dst_base, .len, .stall, .busy, .done,
    .init_we, .init_addr, .init_wdata, .dbg_addr, .dbg_rdata
  );

  always #10 clk_i = ~clk_i;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // a fresh stall pattern every cycle while enabled
  always @(posedge clk_i) begin : stall_gen
    logic [31:0] bits;
    if (stall_en) begin
      take_bits(NCH, bits);
      stall <= bits[NCH-1:0];
    end else begin
      stall <= '0;
    end
  end

  // channel c moves src+c*n+k to dst+c*n+k, so the whole run is one block of NCH*n words
  function automatic word_t expected_word(input addr_t a, input addr_t src, input addr_t dst,
                                          input addr_t n);
    int off;
    off = int'(a) - int'(dst);
    if (off >= 0 && off < int'(NCH) * int'(n)) return image[int'(src) + off];
    return image[a];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "mismatch");
    end
  endtask

  // low bits carry the address, so every word is unique
  task automatic load_image();
    logic [31:0] r;
    for (int a = 0; a < WORDS; a++) begin
      take_bits(`LS_DW - `LS_AW, r);
      @(posedge clk_i);
      init_we    <= 1'b1;
      init_addr  <= addr_t'(a);
      init_wdata <= {r[`LS_DW-`LS_AW-1:0], addr_t'(a)};
      image[a]    = {r[`LS_DW-`LS_AW-1:0], addr_t'(a)};
    end
    @(posedge clk_i);
    init_we <= 1'b0;
  endtask

  task automatic compare_memory(input addr_t src, input addr_t dst, input addr_t n);
    for (int a = 0; a < WORDS; a++) begin
      @(posedge clk_i);
      dbg_addr <= addr_t'(a);
      @(negedge clk_i);
      check($sformatf("dbg_rdata[%03h]", a), dbg_rdata,
            expected_word(addr_t'(a), src, dst, n));
    end
  endtask

  task automatic commit_copy(input addr_t src, input addr_t dst, input addr_t n);
    word_t nxt [WORDS];
    for (int a = 0; a < WORDS; a++) nxt[a] = expected_word(addr_t'(a), src, dst, n);
    image = nxt;
  endtask

  task automatic pulse_start(input addr_t src, input addr_t dst, input addr_t n);
    @(posedge clk_i);
    start_i  <= 1'b1;
    src_base <= src;
    dst_base <= dst;
    len      <= n;
    @(posedge clk_i);
    start_i  <= 1'b0;
  endtask

  task automatic wait_done(input string what);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(negedge clk_i);
      seen = done;
    end
    if (!seen) begin
      $display("timeout: done did not arrive within %0d cycles during %s", TIMEOUT, what);
      $display("Test failures found");
      $fatal(1, "run did not finish");
    end
    check("busy", busy, 1'b0);  // falls together with done
    @(negedge clk_i);
    check("done", done, 1'b0);  // one-cycle pulse
  endtask

  task automatic run_copy(input addr_t src, input addr_t dst, input addr_t n,
                          input logic use_stall, input string what);
    stall_en = use_stall;
    pulse_start(src, dst, n);
    @(negedge clk_i);
    check("busy", busy, 1'b1);
    wait_done(what);
    stall_en = 1'b0;
    compare_memory(src, dst, n);
    commit_copy(src, dst, n);
  endtask

  initial begin
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    start_i    = 1'b0;
    src_base   = '0;
    dst_base   = '0;
    len        = '0;
    init_we    = 1'b0;
    init_addr  = '0;
    init_wdata = '0;
    dbg_addr   = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check("busy", busy, 1'b0);
    check("done", done, 1'b0);
    load_image();
    compare_memory('0, '0, '0);

    run_copy(10'h040, 10'h200, 10'd8, 1'b0, "copy of 8 words");
    run_copy(10'h100, 10'h300, 10'd16, 1'b1, "stalled copy of 16 words");

    // zero length gives done right after start and moves nothing
    pulse_start(10'h010, 10'h020, '0);
    @(negedge clk_i);
    check("done", done, 1'b1);
    check("busy", busy, 1'b0);
    @(negedge clk_i);
    check("done", done, 1'b0);
    compare_memory(10'h010, 10'h020, '0);

    // abort a run halfway
    stall_en = 1'b1;
    pulse_start(10'h080, 10'h280, 10'd16);
    repeat (12) @(negedge clk_i);
    check("busy", busy, 1'b1);
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    check("busy", busy, 1'b0);
    check("done", done, 1'b0);
    repeat (50) begin
      @(negedge clk_i);
      check("done", done, 1'b0);
    end
    stall_en = 1'b0;
    load_image();  // the aborted copy left a partial block behind
    run_copy(10'h180, 10'h380, 10'd12, 1'b1, "copy after clear");

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- tcdm_mem.sv
// shared word memory, one port per channel, no banking and no conflicts
// loads answer one cycle after grant; stalled ports are simply not granted
// init and debug ports are meant for use while the cluster is idle
`timescale 1ns/1ps
`include "ls_cluster_macros.svh"

module tcdm_mem import mem_if_pkg::*, copy_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // channel ports
  input  logic    [`LS_NCH-1:0] mem_req,
  input  mem_op_e [`LS_NCH-1:0] mem_op,
  input  addr_t   [`LS_NCH-1:0] mem_addr,
  input  word_t   [`LS_NCH-1:0] mem_wdata,
  input  logic    [`LS_NCH-1:0] stall,
  output logic    [`LS_NCH-1:0] mem_gnt,
  output logic    [`LS_NCH-1:0] mem_rvalid,
  output word_t   [`LS_NCH-1:0] mem_rdata,

  // testbench access
  input  logic                  init_we,
  input  addr_t                 init_addr,
  input  word_t                 init_wdata,
  input  addr_t                 dbg_addr,
  output word_t                 dbg_rdata
);

  word_t              mem_q [`LS_MEM_WORDS];
  logic [`LS_NCH-1:0] wr_en;
  logic [`LS_NCH-1:0] rd_en;

  assign mem_gnt = mem_req & ~stall;

  always_comb begin
    for (int p = 0; p < `LS_NCH; p++) begin
      wr_en[p] = mem_gnt[p] & (mem_op[p] == MEM_STORE);
      rd_en[p] = mem_gnt[p] & (mem_op[p] == MEM_LOAD);
    end
  end

  // writes land at the granting edge
  always_ff @(posedge clk_i) begin
    if (init_we) begin
      mem_q[init_addr] <= init_wdata;
    end
    for (int p = 0; p < `LS_NCH; p++) begin
      if (wr_en[p]) begin
        mem_q[mem_addr[p]] <= mem_wdata[p];
      end
    end
  end

  // read data, old value on a same-cycle write
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `LS_NCH; p++) begin
      if (rd_en[p]) begin
        mem_rdata[p] <= mem_q[mem_addr[p]];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_rvalid <= '0;
    end else begin
      mem_rvalid <= rd_en;
    end
  end

  assign dbg_rdata = mem_q[dbg_addr];  // combinational peek

  // channel regions are disjoint, so two ports never write one word together
  for (genvar i = 0; i < `LS_NCH; i++) begin : g_chk_i
    for (genvar j = i + 1; j < `LS_NCH; j++) begin : g_chk_j
      a_no_store_clash: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(wr_en[i] && wr_en[j] && mem_addr[i] == mem_addr[j]));
    end
  end

endmodule
